// File: common/fetch_pkg.sv
// Fetch package with widths, boot address, BTB sizes and counter-state enum

package fetch_pkg;

    // ------------------------------------------------------------------------
    // Datapath widths
    // ------------------------------------------------------------------------

    // Address and data width
    localparam int XLEN = 32;

    // Instruction width in bits
    localparam int ILEN = 32;

    // ------------------------------------------------------------------------
    // Boot
    // ------------------------------------------------------------------------

    // First fetch address after reset
    localparam logic [XLEN-1:0] BOOT_PC = 32'h0000_0100;

    // ------------------------------------------------------------------------
    // Branch target buffer geometry
    // ------------------------------------------------------------------------

    // Index bits taken from PC[5:2]
    localparam int BTB_IDX_W = 4;

    // Number of direct-mapped entries
    localparam int BTB_DEPTH = 1 << BTB_IDX_W;

    // Remaining upper PC bits form the tag
    // Two low bits dropped for word alignment
    localparam int BTB_TAG_W = XLEN - BTB_IDX_W - 2;

    // ------------------------------------------------------------------------
    // Branch history counter
    // ------------------------------------------------------------------------

    // 2-bit saturating counter
    // Upper bit set means predict taken
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } bht_state_e;

endpackage

// File: fetch/pc_gen.sv
// Program counter register with next-PC priority select and flush output

module pc_gen (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      except_raised_i,
    input  logic [fetch_pkg::XLEN-1:0] except_pc_i,
    input  logic                      res_valid_i,
    input  logic                      res_mispredict_i,
    input  logic                      res_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] res_pc_i,
    input  logic [fetch_pkg::XLEN-1:0] res_target_i,
    input  logic                      pred_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] pred_target_i,
    input  logic                      fetch_ready_i,
    output logic [fetch_pkg::XLEN-1:0] pc_o,
    output logic                      flush_o
);

    import fetch_pkg::*;

    // Byte step between sequential instructions
    localparam logic [XLEN-1:0] PC_STEP = XLEN'(ILEN / 8);

    logic            mispredict;
    logic [XLEN-1:0] add_base;
    logic [XLEN-1:0] add_out;
    logic [XLEN-1:0] next_pc;

    // ------------------------------------------------------------------------
    // Redirect decode
    // ------------------------------------------------------------------------

    // Mispredict reported by execute
    assign mispredict = res_valid_i & res_mispredict_i;

    // Any redirect kills the younger instruction in the output register
    assign flush_o = except_raised_i | mispredict;

    // ------------------------------------------------------------------------
    // Next PC
    // ------------------------------------------------------------------------

    // One shared adder
    // Branch address on mispredict, else current PC
    assign add_base = mispredict ? res_pc_i : pc_o;
    assign add_out  = add_base + PC_STEP;

    // Exception first, then mispredict, predicted taken and sequential
    always_comb begin
        if (except_raised_i) begin
            next_pc = except_pc_i;
        end else if (mispredict) begin
            // Not-taken fix-up resumes after the branch
            next_pc = res_taken_i ? res_target_i : add_out;
        end else if (pred_taken_i) begin
            next_pc = pred_target_i;
        end else begin
            next_pc = add_out;
        end
    end

    // PC register
    // Redirect loads even while the output stage is stalled
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o <= BOOT_PC;
        end else if (fetch_ready_i || flush_o) begin
            pc_o <= next_pc;
        end
    end

endmodule

// File: fetch/branch_predictor.sv
// Direct-mapped branch target buffer with 2-bit counters, lookup and update

module branch_predictor (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic [fetch_pkg::XLEN-1:0] pc_i,
    input  logic                      res_valid_i,
    input  logic                      res_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] res_pc_i,
    input  logic [fetch_pkg::XLEN-1:0] res_target_i,
    output logic                      pred_taken_o,
    output logic [fetch_pkg::XLEN-1:0] pred_target_o
);

    import fetch_pkg::*;

    // ------------------------------------------------------------------------
    // Entry storage
    // ------------------------------------------------------------------------

    logic                 valid_q  [BTB_DEPTH];
    logic [BTB_TAG_W-1:0] tag_q    [BTB_DEPTH];
    logic [XLEN-1:0]      target_q [BTB_DEPTH];
    bht_state_e           cnt_q    [BTB_DEPTH];

    // Lookup side
    logic [BTB_IDX_W-1:0] rd_idx;
    logic [BTB_TAG_W-1:0] rd_tag;
    logic                 rd_hit;
    bht_state_e           rd_cnt;

    // Update side
    logic [BTB_IDX_W-1:0] wr_idx;
    logic [BTB_TAG_W-1:0] wr_tag;
    logic                 wr_hit;
    logic                 wr_alloc;
    logic                 wr_target;
    bht_state_e           cnt_next;

    // ------------------------------------------------------------------------
    // Lookup at the fetch PC
    // ------------------------------------------------------------------------

    // Index from PC[5:2], tag from the bits above
    assign rd_idx = pc_i[BTB_IDX_W+1:2];
    assign rd_tag = pc_i[XLEN-1:BTB_IDX_W+2];

    assign rd_hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign rd_cnt = cnt_q[rd_idx];

    // Taken only on a hit with a taken-side counter
    assign pred_taken_o  = rd_hit && (rd_cnt == WEAK_T || rd_cnt == STRONG_T);
    assign pred_target_o = target_q[rd_idx];

    // ------------------------------------------------------------------------
    // Resolution update
    // ------------------------------------------------------------------------

    assign wr_idx = res_pc_i[BTB_IDX_W+1:2];
    assign wr_tag = res_pc_i[XLEN-1:BTB_IDX_W+2];

    assign wr_hit = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

    // New entry only for a taken branch that missed
    assign wr_alloc = res_valid_i && !wr_hit && res_taken_i;

    // Target written on allocation or on any taken hit
    assign wr_target = res_valid_i && res_taken_i;

    // Saturating step of the hit counter
    always_comb begin
        cnt_next = cnt_q[wr_idx];
        if (res_taken_i) begin
            case (cnt_q[wr_idx])
                STRONG_NT: cnt_next = WEAK_NT;
                WEAK_NT:   cnt_next = WEAK_T;
                WEAK_T:    cnt_next = STRONG_T;
                default:   cnt_next = STRONG_T;
            endcase
        end else begin
            case (cnt_q[wr_idx])
                STRONG_T:  cnt_next = WEAK_T;
                WEAK_T:    cnt_next = WEAK_NT;
                WEAK_NT:   cnt_next = STRONG_NT;
                default:   cnt_next = STRONG_NT;
            endcase
        end
    end

    // Valid bits and counters
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < BTB_DEPTH; i++) begin
                valid_q[i] <= 1'b0;
                cnt_q[i]   <= STRONG_NT;
            end
        end else if (res_valid_i) begin
            if (wr_hit) begin
                cnt_q[wr_idx] <= cnt_next;
            end else if (wr_alloc) begin
                // Fresh entry starts weakly taken
                valid_q[wr_idx] <= 1'b1;
                cnt_q[wr_idx]   <= WEAK_T;
            end
        end
    end

    // Tags and targets
    always_ff @(posedge clk_i) begin
        if (wr_alloc) begin
            tag_q[wr_idx] <= wr_tag;
        end
        if (wr_target) begin
            target_q[wr_idx] <= res_target_i;
        end
    end

endmodule

// File: fetch/fetch_stage.sv
// Output register toward decode with stall hold and flush of wrong-path work

module fetch_stage (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic [fetch_pkg::XLEN-1:0] pc_i,
    input  logic [fetch_pkg::ILEN-1:0] imem_rdata_i,
    input  logic                      pred_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] pred_target_i,
    input  logic                      flush_i,
    input  logic                      issue_ready_i,
    output logic                      fetch_ready_o,
    output logic                      instr_valid_o,
    output logic [fetch_pkg::ILEN-1:0] instr_o,
    output logic [fetch_pkg::XLEN-1:0] instr_pc_o,
    output logic                      pred_taken_o,
    output logic [fetch_pkg::XLEN-1:0] pred_target_o
);

    import fetch_pkg::*;

    logic            valid_q;
    logic            valid_d;
    logic            load;
    logic [ILEN-1:0] instr_q;
    logic [XLEN-1:0] pc_q;
    logic            pred_taken_q;
    logic [XLEN-1:0] pred_target_q;

    // ------------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------------

    // Room when empty or when decode drains the slot this cycle
    assign fetch_ready_o = !valid_q || issue_ready_i;

    // Flushed fetch is dropped rather than loaded
    assign load = fetch_ready_o && !flush_i;

    // Stays full on a new load or while stalled
    // Accept without a new load empties the slot
    assign valid_d = load || (valid_q && !issue_ready_i && !flush_i);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q      <= 1'b0;
            pred_taken_q <= 1'b0;
        end else begin
            valid_q <= valid_d;
            if (load) begin
                pred_taken_q <= pred_taken_i;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Payload
    // ------------------------------------------------------------------------

    // Held unchanged under back-pressure
    always_ff @(posedge clk_i) begin
        if (load) begin
            instr_q       <= imem_rdata_i;
            pc_q          <= pc_i;
            pred_target_q <= pred_target_i;
        end
    end

    // Outputs to decode
    assign instr_valid_o = valid_q;
    assign instr_o       = instr_q;
    assign instr_pc_o    = pc_q;
    assign pred_taken_o  = pred_taken_q;
    assign pred_target_o = pred_target_q;

endmodule

// File: fetch/fetch_unit.sv
// Fetch front end top level joining PC generator, predictor and output stage

module fetch_unit (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    // Exception redirect
    input  logic                      except_raised_i,
    input  logic [fetch_pkg::XLEN-1:0] except_pc_i,
    // Branch resolution from execute
    input  logic                      res_valid_i,
    input  logic                      res_mispredict_i,
    input  logic                      res_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] res_pc_i,
    input  logic [fetch_pkg::XLEN-1:0] res_target_i,
    // Instruction memory
    output logic [fetch_pkg::XLEN-1:0] imem_addr_o,
    input  logic [fetch_pkg::ILEN-1:0] imem_rdata_i,
    // Decode side
    output logic                      instr_valid_o,
    output logic [fetch_pkg::ILEN-1:0] instr_o,
    output logic [fetch_pkg::XLEN-1:0] instr_pc_o,
    output logic                      pred_taken_o,
    output logic [fetch_pkg::XLEN-1:0] pred_target_o,
    input  logic                      issue_ready_i
);

    import fetch_pkg::*;

    logic [XLEN-1:0] pc;
    logic            pred_taken;
    logic [XLEN-1:0] pred_target;
    logic            fetch_ready;
    logic            flush;

    // Memory is read at the current PC
    assign imem_addr_o = pc;

    // ------------------------------------------------------------------------
    // Stage 1 PC and prediction
    // ------------------------------------------------------------------------

    pc_gen u_pc_gen (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .except_raised_i  (except_raised_i),
        .except_pc_i      (except_pc_i),
        .res_valid_i      (res_valid_i),
        .res_mispredict_i (res_mispredict_i),
        .res_taken_i      (res_taken_i),
        .res_pc_i         (res_pc_i),
        .res_target_i     (res_target_i),
        .pred_taken_i     (pred_taken),
        .pred_target_i    (pred_target),
        .fetch_ready_i    (fetch_ready),
        .pc_o             (pc),
        .flush_o          (flush)
    );

    branch_predictor u_bpred (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .pc_i          (pc),
        .res_valid_i   (res_valid_i),
        .res_taken_i   (res_taken_i),
        .res_pc_i      (res_pc_i),
        .res_target_i  (res_target_i),
        .pred_taken_o  (pred_taken),
        .pred_target_o (pred_target)
    );

    // ------------------------------------------------------------------------
    // Stage 2 output register
    // ------------------------------------------------------------------------

    fetch_stage u_fetch_stage (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .pc_i          (pc),
        .imem_rdata_i  (imem_rdata_i),
        .pred_taken_i  (pred_taken),
        .pred_target_i (pred_target),
        .flush_i       (flush),
        .issue_ready_i (issue_ready_i),
        .fetch_ready_o (fetch_ready),
        .instr_valid_o (instr_valid_o),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o),
        .pred_taken_o  (pred_taken_o),
        .pred_target_o (pred_target_o)
    );

endmodule

// File: bench/fetch_unit_props.sv
// Bound assertions for decode stall hold, flush kill and counter saturation

module fetch_unit_props (
    input logic                       clk_i,
    input logic                       rst_n_i,
    input logic                       flush_i,
    input logic                       issue_ready_i,
    input logic                       instr_valid_i,
    input logic [fetch_pkg::ILEN-1:0] instr_i,
    input logic [fetch_pkg::XLEN-1:0] instr_pc_i,
    input logic                       pred_taken_i,
    input logic [fetch_pkg::XLEN-1:0] pred_target_i,
    input logic                       res_valid_i,
    input logic                       res_taken_i,
    input logic                       upd_hit_i,
    input fetch_pkg::bht_state_e      cnt_next_i
);

    import fetch_pkg::*;

    // Stalled output keeps valid and payload
    property p_stall_hold;
        @(posedge clk_i) disable iff (!rst_n_i)
        (instr_valid_i && !issue_ready_i && !flush_i) |=>
            (instr_valid_i && $stable(instr_i) && $stable(instr_pc_i)
             && $stable(pred_taken_i) && $stable(pred_target_i));
    endproperty

    // Wrong-path slot is empty after a redirect
    property p_flush_kill;
        @(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> !instr_valid_i;
    endproperty

    // Hit update never wraps around the end of the counter range
    property p_cnt_saturate;
        @(posedge clk_i) disable iff (!rst_n_i)
        (res_valid_i && upd_hit_i) |->
            (res_taken_i ? (cnt_next_i != STRONG_NT) : (cnt_next_i != STRONG_T));
    endproperty

    a_stall_hold: assert property (p_stall_hold)
        else $error("decode outputs changed while stalled");

    a_flush_kill: assert property (p_flush_kill)
        else $error("instr_valid_o high in the cycle after flush");

    a_cnt_saturate: assert property (p_cnt_saturate)
        else $error("branch counter wrapped instead of saturating");

endmodule

bind fetch_unit fetch_unit_props u_props (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush),
    .issue_ready_i (issue_ready_i),
    .instr_valid_i (instr_valid_o),
    .instr_i       (instr_o),
    .instr_pc_i    (instr_pc_o),
    .pred_taken_i  (pred_taken_o),
    .pred_target_i (pred_target_o),
    .res_valid_i   (res_valid_i),
    .res_taken_i   (res_taken_i),
    .upd_hit_i     (u_bpred.wr_hit),
    .cnt_next_i    (u_bpred.cnt_next)
);

// File: bench/tb_fetch_unit.sv
// Fetch unit testbench with clock, reset, memory model, test table, checks and timeout

module tb_fetch_unit;

    import fetch_pkg::*;

    // One row of the test table
    // Expected accepts are a run from a_pc followed by a run from b_pc
    typedef struct {
        string           name;
        logic            start_flush;
        logic [XLEN-1:0] trig_pc;
        logic [1:0]      kind;      // bit 1 exception, bit 0 resolution
        logic [XLEN-1:0] except_pc;
        logic            mis;
        logic            taken;
        logic [XLEN-1:0] res_pc;
        logic [XLEN-1:0] res_target;
        logic            rand_ready;
        logic [XLEN-1:0] a_pc;
        int              a_n;
        logic [XLEN-1:0] b_pc;
        int              b_n;
        int              pred_idx;
    } row_t;

    logic            clk_i;
    logic            rst_n_i;
    logic            except_raised_i;
    logic [XLEN-1:0] except_pc_i;
    logic            res_valid_i;
    logic            res_mispredict_i;
    logic            res_taken_i;
    logic [XLEN-1:0] res_pc_i;
    logic [XLEN-1:0] res_target_i;
    logic [XLEN-1:0] imem_addr_o;
    logic [ILEN-1:0] imem_rdata_i;
    logic            instr_valid_o;
    logic [ILEN-1:0] instr_o;
    logic [XLEN-1:0] instr_pc_o;
    logic            pred_taken_o;
    logic [XLEN-1:0] pred_target_o;
    logic            issue_ready_i;

    row_t            rows [16];
    int              n_rows;
    logic [XLEN-1:0] exp_pc_q [$];
    logic            exp_pred_q [$];
    string           cur_name;
    int              mismatch_count;
    int              other_count;
    int              cycle_count;
    int              timeout_limit = 0;
    int              total_accepts;

    fetch_unit u_dut (.*);

    always #4 clk_i = ~clk_i;

    // Word at address A is the inverse of A
    assign imem_rdata_i = ~imem_addr_o;

    // ------------------------------------------------------------------------
    // Test table
    // ------------------------------------------------------------------------

    task automatic add_row(input string name, input logic flush, input logic [XLEN-1:0] trig,
                           input logic [1:0] kind, input logic [XLEN-1:0] xpc,
                           input logic mis, input logic tkn, input logic [XLEN-1:0] rpc,
                           input logic [XLEN-1:0] rtgt, input logic rnd,
                           input logic [XLEN-1:0] a_pc, input int a_n,
                           input logic [XLEN-1:0] b_pc, input int b_n, input int pidx);
        rows[n_rows].name        = name;
        rows[n_rows].start_flush = flush;
        rows[n_rows].trig_pc     = trig;
        rows[n_rows].kind        = kind;
        rows[n_rows].except_pc   = xpc;
        rows[n_rows].mis         = mis;
        rows[n_rows].taken       = tkn;
        rows[n_rows].res_pc      = rpc;
        rows[n_rows].res_target  = rtgt;
        rows[n_rows].rand_ready  = rnd;
        rows[n_rows].a_pc        = a_pc;
        rows[n_rows].a_n         = a_n;
        rows[n_rows].b_pc        = b_pc;
        rows[n_rows].b_n         = b_n;
        rows[n_rows].pred_idx    = pidx;
        n_rows++;
    endtask

    task automatic load_table();
        add_row("boot_seq", 1'b0, 32'h0, 2'b00, 32'h0, 1'b0, 1'b0, 32'h0, 32'h0,
                1'b0, BOOT_PC, 6, 32'h0, 0, -1);
        add_row("stall_seq", 1'b1, 32'h0, 2'b00, 32'h0, 1'b0, 1'b0, 32'h0, 32'h0,
                1'b1, 32'h200, 6, 32'h0, 0, -1);
        add_row("except_redirect", 1'b1, 32'h30C, 2'b10, 32'h400, 1'b0, 1'b0, 32'h0, 32'h0,
                1'b0, 32'h300, 3, 32'h400, 3, -1);
        add_row("mispredict_nt", 1'b1, 32'h50C, 2'b01, 32'h0, 1'b1, 1'b0, 32'h540, 32'h0,
                1'b0, 32'h500, 3, 32'h544, 3, -1);
        add_row("mispredict_t", 1'b1, 32'h608, 2'b01, 32'h0, 1'b1, 1'b1, 32'h610, 32'h700,
                1'b0, 32'h600, 2, 32'h700, 3, -1);
        // Entry for 0x610 now weakly taken
        add_row("learned_taken", 1'b1, 32'h0, 2'b00, 32'h0, 1'b0, 1'b0, 32'h0, 32'h0,
                1'b0, 32'h608, 3, 32'h700, 2, 2);
        add_row("unlearn_first", 1'b1, 32'h808, 2'b01, 32'h0, 1'b1, 1'b0, 32'h610, 32'h0,
                1'b0, 32'h800, 2, 32'h614, 3, -1);
        // Correctly predicted not taken so no redirect
        add_row("unlearn_second", 1'b1, 32'h904, 2'b01, 32'h0, 1'b0, 1'b0, 32'h610, 32'h0,
                1'b0, 32'h900, 5, 32'h0, 0, -1);
        add_row("learned_nt", 1'b1, 32'h0, 2'b00, 32'h0, 1'b0, 1'b0, 32'h0, 32'h0,
                1'b0, 32'h608, 5, 32'h0, 0, -1);
        add_row("except_priority", 1'b1, 32'hA08, 2'b11, 32'hB00, 1'b1, 1'b1, 32'hA40,
                32'hC00, 1'b0, 32'hA00, 2, 32'hB00, 3, -1);
    endtask

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("MISMATCH test %s %s expected %08h actual %08h", cur_name, what, exp, act);
        mismatch_count++;
    endtask

    task automatic check_accept();
        logic [XLEN-1:0] exp_pc;
        logic            exp_pred;
        exp_pc   = exp_pc_q.pop_front();
        exp_pred = exp_pred_q.pop_front();
        if (instr_pc_o != exp_pc) begin
            report_mismatch("instr_pc_o", exp_pc, instr_pc_o);
        end
        if (instr_o != ~exp_pc) begin
            report_mismatch("instr_o", ~exp_pc, instr_o);
        end
        if (pred_taken_o != exp_pred) begin
            report_mismatch("pred_taken_o", 32'(exp_pred), 32'(pred_taken_o));
        end
        // Predicted target is the next accepted PC
        if (exp_pred && exp_pc_q.size() != 0 && pred_target_o != exp_pc_q[0]) begin
            report_mismatch("pred_target_o", exp_pc_q[0], pred_target_o);
        end
    endtask

    // Inputs are settled here ahead of the accepting edge
    always @(negedge clk_i) begin
        if (rst_n_i && instr_valid_o && issue_ready_i) begin
            check_accept();
        end
    end

    // ------------------------------------------------------------------------
    // Row driver
    // ------------------------------------------------------------------------

    task automatic run_row(input int r);
        logic        fired;
        logic [31:0] rnd_word;
        fired = 1'b0;
        // Redirect to the start address while decode is stalled
        if (rows[r].start_flush) begin
            except_raised_i = 1'b1;
            except_pc_i     = rows[r].a_pc;
            @(posedge clk_i);
            #1;
            except_raised_i = 1'b0;
        end
        cur_name = rows[r].name;
        for (int k = 0; k < rows[r].a_n + rows[r].b_n; k++) begin
            if (k < rows[r].a_n) begin
                exp_pc_q.push_back(rows[r].a_pc + 32'(4 * k));
            end else begin
                exp_pc_q.push_back(rows[r].b_pc + 32'(4 * (k - rows[r].a_n)));
            end
            exp_pred_q.push_back(k == rows[r].pred_idx);
        end
        while (exp_pc_q.size() != 0) begin
            if (rows[r].rand_ready) begin
                rnd_word      = $urandom;
                issue_ready_i = rnd_word[0];
            end else begin
                issue_ready_i = 1'b1;
            end
            // Strobe once in the first cycle that fetches the trigger PC
            if (!fired && rows[r].kind != 2'b00 && imem_addr_o == rows[r].trig_pc) begin
                except_raised_i  = rows[r].kind[1];
                except_pc_i      = rows[r].except_pc;
                res_valid_i      = rows[r].kind[0];
                res_mispredict_i = rows[r].mis;
                res_taken_i      = rows[r].taken;
                res_pc_i         = rows[r].res_pc;
                res_target_i     = rows[r].res_target;
                fired            = 1'b1;
            end
            @(posedge clk_i);
            #1;
            except_raised_i  = 1'b0;
            res_valid_i      = 1'b0;
            res_mispredict_i = 1'b0;
            res_taken_i      = 1'b0;
        end
        issue_ready_i = 1'b0;
        if (rows[r].kind != 2'b00 && !fired) begin
            $display("ERROR: test %s never reached pc %08h to apply its strobe",
                     cur_name, rows[r].trig_pc);
            other_count++;
        end
    endtask

    initial begin
        void'($urandom(32'h4059277b));
        clk_i            = 1'b0;
        rst_n_i          = 1'b0;
        except_raised_i  = 1'b0;
        except_pc_i      = '0;
        res_valid_i      = 1'b0;
        res_mispredict_i = 1'b0;
        res_taken_i      = 1'b0;
        res_pc_i         = '0;
        res_target_i     = '0;
        issue_ready_i    = 1'b0;
        mismatch_count   = 0;
        other_count      = 0;
        n_rows           = 0;
        total_accepts    = 0;
        cur_name         = "reset";
        load_table();
        for (int r = 0; r < n_rows; r++) begin
            total_accepts += rows[r].a_n + rows[r].b_n;
        end
        timeout_limit = 4 * total_accepts + 100;
        repeat (8) @(posedge clk_i);
        #1;
        // Reset state
        if (imem_addr_o != BOOT_PC) begin
            report_mismatch("imem_addr_o", BOOT_PC, imem_addr_o);
        end
        if (instr_valid_o || pred_taken_o) begin
            $display("ERROR: instr_valid_o or pred_taken_o is high during reset");
            other_count++;
        end
        rst_n_i = 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        cycle_count = 0;
        wait (timeout_limit > 0);
        while (cycle_count < timeout_limit) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("ERROR: timeout after %0d cycles in test %s, expected instructions never came",
                 cycle_count, cur_name);
        other_count++;
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: tb.f
common/fetch_pkg.sv
fetch/pc_gen.sv
fetch/branch_predictor.sv
fetch/fetch_stage.sv
fetch/fetch_unit.sv
bench/fetch_unit_props.sv
bench/tb_fetch_unit.sv

// File: Makefile
# Verilator build and run of the fetch unit testbench

OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f tb.f --top-module tb_fetch_unit \
		-Mdir $(OBJ_DIR) -o Vtb_fetch_unit
	./$(OBJ_DIR)/Vtb_fetch_unit 2>&1 | tee $(LOG)
	@if grep -q "^Simulation PASSED$$" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
